/* Bender.yml */
package:
  name: match3_core

sources:
  - files:
      - board_pkg.sv
      - control_pkg.sv
      - cell_lfsr.sv
      - scan_counter.sv
      - match_finder.sv
      - board_store.sv
      - cursor_ctrl.sv
      - game_fsm.sv
      - match3_core.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_match3_core.sv

/* board_pkg.sv */
package board_pkg;

    // --------------------
    // board geometry
    // --------------------
    localparam int grid_rows = 8;
    localparam int grid_cols = 8;

    typedef logic [2:0] row_t;
    typedef logic [2:0] col_t;

    // --------------------
    // cell codes
    // --------------------
    typedef logic [2:0] cell_t;

    // gem codes run 0 to gem_kinds-1
    localparam int gem_kinds = 5;

    // no gem in this cell
    localparam cell_t cell_empty = 3'd7;

    // shortest line of equal gems that clears
    localparam int run_length = 3;

    // --------------------
    // whole-board views
    // --------------------

    // indexed [row][col], row 0 at the top
    typedef cell_t [grid_rows-1:0][grid_cols-1:0] board_t;

    // one flag per cell, same indexing as board_t
    typedef logic [grid_rows-1:0][grid_cols-1:0] mask_t;

endpackage

/* board_store.sv */
`timescale 1ns/10ps

module board_store (
    input  logic               clk,
    input  logic               reset,
    input  logic               fill_en,
    input  logic               grav_en,
    input  logic               clear_en,
    input  logic               swap_commit,
    input  board_pkg::row_t    scan_row,
    input  board_pkg::col_t    scan_col,
    input  board_pkg::cell_t   gem,
    input  board_pkg::row_t    cursor_row,
    input  board_pkg::col_t    cursor_col,
    input  control_pkg::dir_t  swap_dir,
    input  board_pkg::mask_t   clear_mask,
    input  board_pkg::row_t    rd_row,
    input  board_pkg::col_t    rd_col,
    output board_pkg::board_t  board,
    output board_pkg::board_t  trial,
    output board_pkg::cell_t   rd_cell,
    output logic               grav_moved
);
    import board_pkg::*;
    import control_pkg::*;

    row_t below_row;

    // --------------------
    // trial board
    // --------------------
    // no direction means the neighbour is the cursor cell itself
    always_comb begin
        row_t nb_row;
        col_t nb_col;
        nb_row = cursor_row;
        nb_col = cursor_col;
        case (swap_dir)
            dir_left:  nb_col = cursor_col - 1'b1;
            dir_right: nb_col = cursor_col + 1'b1;
            dir_up:    nb_row = cursor_row - 1'b1;
            dir_down:  nb_row = cursor_row + 1'b1;
            default:   ;
        endcase
        trial = board;
        trial[cursor_row][cursor_col] = board[nb_row][nb_col];
        trial[nb_row][nb_col] = board[cursor_row][cursor_col];
    end

    // --------------------
    // gravity step
    // --------------------
    assign below_row = scan_row + 1'b1;

    // gem over an empty cell drops one row, bottom row has nothing below
    assign grav_moved = grav_en
                     && (scan_row != row_t'(grid_rows - 1))
                     && (board[scan_row][scan_col] != cell_empty)
                     && (board[below_row][scan_col] == cell_empty);

    // --------------------
    // cell registers
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board <= {grid_rows*grid_cols{cell_empty}};
        end else if (swap_commit) begin
            board <= trial;
        end else if (fill_en) begin
            board[scan_row][scan_col] <= gem;
        end else if (grav_moved) begin
            board[scan_row][scan_col] <= cell_empty;
            board[below_row][scan_col] <= board[scan_row][scan_col];
        end else if (clear_en) begin
            for (int r = 0; r < grid_rows; r++) begin
                for (int c = 0; c < grid_cols; c++) begin
                    if (clear_mask[r][c]) begin
                        board[r][c] <= cell_empty;
                    end
                end
            end
        end
    end

    // random-access read port
    assign rd_cell = board[rd_row][rd_col];

endmodule

/* cell_lfsr.sv */
`timescale 1ns/10ps

module cell_lfsr (
    input  logic             clk,
    input  logic             reset,
    output board_pkg::cell_t gem,
    output logic             draw_ok
);
    import board_pkg::*;

    logic [15:0] lfsr;

    // 16-bit fibonacci lfsr, taps 16 15 13 4
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
        end
    end

    // low three bits minus one, so a zero field wraps to the empty code
    assign gem = lfsr[2:0] - 3'd1;

    // codes 5 and up are not gems, fill waits for another draw
    assign draw_ok = (gem < gem_kinds);

endmodule

/* control_pkg.sv */
package control_pkg;

    // --------------------
    // engine states
    // --------------------
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_fill    = 2'd1,
        st_gravity = 2'd2,
        st_clear   = 2'd3
    } engine_state_t;

    // --------------------
    // player directions
    // --------------------
    typedef enum logic [2:0] {
        dir_none  = 3'd0,
        dir_left  = 3'd1,
        dir_right = 3'd2,
        dir_up    = 3'd3,
        dir_down  = 3'd4
    } dir_t;

endpackage

/* cursor_ctrl.sv */
`timescale 1ns/10ps

module cursor_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic              left,
    input  logic              right,
    input  logic              up,
    input  logic              down,
    input  logic              enter,
    output board_pkg::row_t   cursor_row,
    output board_pkg::col_t   cursor_col,
    output logic              selected,
    output logic              swap_try,
    output control_pkg::dir_t swap_dir
);
    import board_pkg::*;
    import control_pkg::*;

    dir_t req_dir;
    logic has_neighbour;

    // first pressed direction wins
    always_comb begin
        req_dir = dir_none;
        if (left) begin
            req_dir = dir_left;
        end else if (right) begin
            req_dir = dir_right;
        end else if (up) begin
            req_dir = dir_up;
        end else if (down) begin
            req_dir = dir_down;
        end
    end

    // is there a cell on that side of the cursor
    always_comb begin
        case (req_dir)
            dir_left:  has_neighbour = (cursor_col != '0);
            dir_right: has_neighbour = (cursor_col != col_t'(grid_cols - 1));
            dir_up:    has_neighbour = (cursor_row != '0);
            dir_down:  has_neighbour = (cursor_row != row_t'(grid_rows - 1));
            default:   has_neighbour = 1'b0;
        endcase
    end

    // --------------------
    // swap request
    // --------------------
    assign swap_try = enable && !enter && selected && has_neighbour;
    assign swap_dir = swap_try ? req_dir : dir_none;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cursor_row <= '0;
            cursor_col <= '0;
            selected   <= 1'b0;
        end else if (enable) begin
            if (enter) begin
                selected <= ~selected;
            end else if (req_dir != dir_none) begin
                // a try or an edge cancel both drop the selection
                if (selected) begin
                    selected <= 1'b0;
                end else if (has_neighbour) begin
                    case (req_dir)
                        dir_left:  cursor_col <= cursor_col - 1'b1;
                        dir_right: cursor_col <= cursor_col + 1'b1;
                        dir_up:    cursor_row <= cursor_row - 1'b1;
                        dir_down:  cursor_row <= cursor_row + 1'b1;
                        default:   ;
                    endcase
                end
            end
        end
    end

endmodule

/* game_fsm.sv */
`timescale 1ns/10ps

module game_fsm (
    input  logic clk,
    input  logic reset,
    input  logic game_reset,
    input  logic swap_try,
    input  logic trial_match,
    input  logic board_match,
    input  logic draw_ok,
    input  logic scan_last,
    input  logic grav_moved,
    output logic fill_en,
    output logic grav_en,
    output logic clear_en,
    output logic swap_commit,
    output logic scan_start,
    output logic scan_step,
    output logic busy
);
    import control_pkg::*;

    engine_state_t state;
    engine_state_t state_next;
    logic          moved_any;
    logic          sweep_again;

    // --------------------
    // strobes
    // --------------------
    assign fill_en  = (state == st_fill) && draw_ok;
    assign grav_en  = (state == st_gravity);
    assign clear_en = (state == st_clear);

    // new board takes priority over a swap in the same cycle
    assign swap_commit = (state == st_idle) && swap_try && trial_match && !game_reset;

    // anything moved during this sweep, last cell included
    assign sweep_again = moved_any || grav_moved;

    assign scan_step  = fill_en || grav_en;
    assign scan_start = ((state == st_idle) && (game_reset || swap_commit))
                     || ((state == st_gravity) && scan_last && sweep_again)
                     || (clear_en && board_match);

    assign busy = (state != st_idle);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (game_reset) begin
                    state_next = st_fill;
                end else if (swap_commit) begin
                    state_next = st_gravity;
                end
            end
            st_fill: begin
                if (fill_en && scan_last) begin
                    state_next = st_gravity;
                end
            end
            st_gravity: begin
                // a quiet sweep means the columns are packed
                if (scan_last && !sweep_again) begin
                    state_next = st_clear;
                end
            end
            st_clear: begin
                state_next = board_match ? st_gravity : st_idle;
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_idle;
            moved_any <= 1'b0;
        end else begin
            state <= state_next;
            if (scan_start) begin
                moved_any <= 1'b0;
            end else if (grav_moved) begin
                moved_any <= 1'b1;
            end
        end
    end

endmodule

/* match3_core.f */
board_pkg.sv
control_pkg.sv
cell_lfsr.sv
scan_counter.sv
match_finder.sv
board_store.sv
cursor_ctrl.sv
game_fsm.sv
match3_core.sv
tb_checker.sv
tb_match3_core.sv

/* match3_core.sv */
`timescale 1ns/10ps

module match3_core (
    input  logic             clk,
    input  logic             reset,
    input  logic             left,
    input  logic             right,
    input  logic             up,
    input  logic             down,
    input  logic             enter,
    input  logic             game_reset,
    input  board_pkg::row_t  rd_row,
    input  board_pkg::col_t  rd_col,
    output board_pkg::cell_t rd_cell,
    output board_pkg::row_t  cursor_row,
    output board_pkg::col_t  cursor_col,
    output logic             selected,
    output logic             busy
);
    import board_pkg::*;
    import control_pkg::*;

    cell_t  gem;
    logic   draw_ok;
    row_t   scan_row;
    col_t   scan_col;
    logic   scan_last;
    logic   scan_start;
    logic   scan_step;
    board_t board;
    board_t trial;
    mask_t  clear_mask;
    mask_t  trial_mask;
    logic   grav_moved;
    logic   swap_try;
    dir_t   swap_dir;
    logic   fill_en;
    logic   grav_en;
    logic   clear_en;
    logic   swap_commit;

    // --------------------
    // datapath
    // --------------------
    cell_lfsr u_cell_lfsr (
        .clk     (clk),
        .reset   (reset),
        .gem     (gem),
        .draw_ok (draw_ok)
    );

    scan_counter u_scan_counter (
        .clk       (clk),
        .reset     (reset),
        .start     (scan_start),
        .step      (scan_step),
        .scan_row  (scan_row),
        .scan_col  (scan_col),
        .scan_last (scan_last)
    );

    board_store u_board_store (
        .clk         (clk),
        .reset       (reset),
        .fill_en     (fill_en),
        .grav_en     (grav_en),
        .clear_en    (clear_en),
        .swap_commit (swap_commit),
        .scan_row    (scan_row),
        .scan_col    (scan_col),
        .gem         (gem),
        .cursor_row  (cursor_row),
        .cursor_col  (cursor_col),
        .swap_dir    (swap_dir),
        .clear_mask  (clear_mask),
        .rd_row      (rd_row),
        .rd_col      (rd_col),
        .board       (board),
        .trial       (trial),
        .rd_cell     (rd_cell),
        .grav_moved  (grav_moved)
    );

    // live board feeds the clear step
    match_finder u_board_matches (
        .cells (board),
        .mask  (clear_mask)
    );

    // trial board decides whether a swap is kept
    match_finder u_trial_matches (
        .cells (trial),
        .mask  (trial_mask)
    );

    // --------------------
    // control
    // --------------------
    // player input only counts while the engine is idle
    cursor_ctrl u_cursor_ctrl (
        .clk        (clk),
        .reset      (reset),
        .enable     (~busy),
        .left       (left),
        .right      (right),
        .up         (up),
        .down       (down),
        .enter      (enter),
        .cursor_row (cursor_row),
        .cursor_col (cursor_col),
        .selected   (selected),
        .swap_try   (swap_try),
        .swap_dir   (swap_dir)
    );

    game_fsm u_game_fsm (
        .clk         (clk),
        .reset       (reset),
        .game_reset  (game_reset),
        .swap_try    (swap_try),
        .trial_match (|trial_mask),
        .board_match (|clear_mask),
        .draw_ok     (draw_ok),
        .scan_last   (scan_last),
        .grav_moved  (grav_moved),
        .fill_en     (fill_en),
        .grav_en     (grav_en),
        .clear_en    (clear_en),
        .swap_commit (swap_commit),
        .scan_start  (scan_start),
        .scan_step   (scan_step),
        .busy        (busy)
    );

endmodule

/* match_finder.sv */
`timescale 1ns/10ps

module match_finder (
    input  board_pkg::board_t cells,
    output board_pkg::mask_t  mask
);
    import board_pkg::*;

    always_comb begin
        logic hit;
        mask = '0;
        hit  = 1'b0;

        // --------------------
        // horizontal runs
        // --------------------
        for (int r = 0; r < grid_rows; r++) begin
            for (int c = 0; c <= grid_cols - run_length; c++) begin
                hit = (cells[r][c] != cell_empty);
                for (int j = 1; j < run_length; j++) begin
                    hit = hit && (cells[r][c+j] == cells[r][c]);
                end
                // overlapping windows cover runs longer than three
                if (hit) begin
                    for (int j = 0; j < run_length; j++) begin
                        mask[r][c+j] = 1'b1;
                    end
                end
            end
        end

        // --------------------
        // vertical runs
        // --------------------
        for (int c = 0; c < grid_cols; c++) begin
            for (int r = 0; r <= grid_rows - run_length; r++) begin
                hit = (cells[r][c] != cell_empty);
                for (int j = 1; j < run_length; j++) begin
                    hit = hit && (cells[r+j][c] == cells[r][c]);
                end
                if (hit) begin
                    for (int j = 0; j < run_length; j++) begin
                        mask[r+j][c] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* scan_counter.sv */
`timescale 1ns/10ps

module scan_counter (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            step,
    output board_pkg::row_t scan_row,
    output board_pkg::col_t scan_col,
    output logic            scan_last
);
    import board_pkg::*;

    localparam row_t last_row = row_t'(grid_rows - 1);
    localparam col_t last_col = col_t'(grid_cols - 1);

    // row-major sweep, columns advance fastest
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_row <= '0;
            scan_col <= '0;
        end else if (start) begin
            scan_row <= '0;
            scan_col <= '0;
        end else if (step) begin
            if (scan_col == last_col) begin
                scan_col <= '0;
                // wraps back to the top after the last cell
                if (scan_row == last_row) begin
                    scan_row <= '0;
                end else begin
                    scan_row <= scan_row + 1'b1;
                end
            end else begin
                scan_col <= scan_col + 1'b1;
            end
        end
    end

    // bottom right corner ends the sweep
    assign scan_last = (scan_row == last_row) && (scan_col == last_col);

endmodule

/* tb_checker.sv */
`timescale 1ns/10ps

module tb_checker (
    input  logic             clk,
    input  board_pkg::row_t  cursor_row,
    input  board_pkg::col_t  cursor_col,
    input  logic             selected,
    input  logic             busy,
    input  board_pkg::cell_t rd_cell,
    input  board_pkg::row_t  rd_row,
    input  board_pkg::col_t  rd_col,
    input  logic             exp_valid,
    input  board_pkg::row_t  exp_row,
    input  board_pkg::col_t  exp_col,
    input  logic             exp_sel,
    input  logic             exp_busy,
    input  logic             cell_valid,
    input  board_pkg::cell_t exp_cell,
    output int               error_count,
    output int               check_count
);
    import board_pkg::*;

    row_t last_row;
    col_t last_col;
    logic last_sel;
    logic last_busy;

    initial begin
        error_count = 0;
        check_count = 0;
        last_row    = '0;
        last_col    = '0;
        last_sel    = 1'b0;
        last_busy   = 1'b0;
    end

    // one compare, x or z on the DUT side counts as a mismatch
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    // --------------------
    // sampling
    // --------------------
    // outputs are settled half a cycle after the driving edge
    always @(negedge clk) begin
        if (exp_valid) begin
            compare_value("cursor_row", cursor_row, exp_row);
            compare_value("cursor_col", cursor_col, exp_col);
            compare_value("selected", selected, exp_sel);
            compare_value("busy", busy, exp_busy);
        end
        if (cell_valid) begin
            compare_value($sformatf("rd_cell[%0d][%0d]", rd_row, rd_col), rd_cell, exp_cell);
        end

        // player input must not reach the cursor during a settle
        if (last_busy && busy && (cursor_row !== last_row || cursor_col !== last_col
                                  || selected !== last_sel)) begin
            error_count++;
            $display("cursor or selection changed at %0t while the engine was busy", $time);
        end
        last_row  <= cursor_row;
        last_col  <= cursor_col;
        last_sel  <= selected;
        last_busy <= busy;
    end

endmodule

/* tb_match3_core.sv */
`timescale 1ns/10ps

module tb_match3_core;
    import board_pkg::*;

    localparam int a_left        = 0;
    localparam int a_right       = 1;
    localparam int a_up          = 2;
    localparam int a_down        = 3;
    localparam int a_enter       = 4;
    localparam int a_enter_right = 5;
    localparam int a_fill        = 6;
    localparam int a_hunt        = 7;
    localparam int a_miss        = 8;
    localparam int max_entries   = 64;
    localparam int empty_code    = cell_empty;

    logic  clk;
    logic  reset;
    logic  left;
    logic  right;
    logic  up;
    logic  down;
    logic  enter;
    logic  game_reset;
    row_t  rd_row;
    col_t  rd_col;
    cell_t rd_cell;
    row_t  cursor_row;
    col_t  cursor_col;
    logic  selected;
    logic  busy;

    logic  exp_valid;
    row_t  exp_row;
    col_t  exp_col;
    logic  exp_sel;
    logic  exp_busy;
    logic  cell_valid;
    cell_t exp_cell;
    int    error_count;
    int    check_count;

    // stimulus table, one row per action
    int tbl_act [max_entries];
    int tbl_row [max_entries];
    int tbl_col [max_entries];
    bit tbl_sel [max_entries];
    int n_entries;

    // reference board, row-major, plus a scratch copy
    int mdl [64];
    int work [64];
    bit run_mark [64];
    int cur_r;
    int cur_c;
    bit cur_sel;
    int cycles;
    int cycle_limit;

    match3_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .left       (left),
        .right      (right),
        .up         (up),
        .down       (down),
        .enter      (enter),
        .game_reset (game_reset),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .rd_cell    (rd_cell),
        .cursor_row (cursor_row),
        .cursor_col (cursor_col),
        .selected   (selected),
        .busy       (busy)
    );

    tb_checker chk0 (
        .clk         (clk),
        .cursor_row  (cursor_row),
        .cursor_col  (cursor_col),
        .selected    (selected),
        .busy        (busy),
        .rd_cell     (rd_cell),
        .rd_row      (rd_row),
        .rd_col      (rd_col),
        .exp_valid   (exp_valid),
        .exp_row     (exp_row),
        .exp_col     (exp_col),
        .exp_sel     (exp_sel),
        .exp_busy    (exp_busy),
        .cell_valid  (cell_valid),
        .exp_cell    (exp_cell),
        .error_count (error_count),
        .check_count (check_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the engine never went idle", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic int cell_index(int line, int pos, bit vert);
        return vert ? pos * 8 + line : line * 8 + pos;
    endfunction

    // mark every cell on a line of three or more equal gems
    function automatic bit find_runs();
        int len;
        int here;
        int prev;
        bit any;
        any = 1'b0;
        for (int i = 0; i < 64; i++) begin
            run_mark[i] = 1'b0;
        end
        for (int v = 0; v < 2; v++) begin
            for (int line = 0; line < 8; line++) begin
                len = 1;
                for (int pos = 1; pos <= 8; pos++) begin
                    here = (pos < 8) ? work[cell_index(line, pos, v)] : empty_code;
                    prev = work[cell_index(line, pos - 1, v)];
                    if (here != empty_code && here == prev) begin
                        len++;
                    end else begin
                        if (len >= 3) begin
                            any = 1'b1;
                            for (int k = pos - len; k < pos; k++) begin
                                run_mark[cell_index(line, k, v)] = 1'b1;
                            end
                        end
                        len = 1;
                    end
                end
            end
        end
        return any;
    endfunction

    // gems slide to the bottom of each column, order kept
    task automatic compact_work();
        int dst;
        for (int c = 0; c < 8; c++) begin
            dst = 7;
            for (int r = 7; r >= 0; r--) begin
                if (work[r * 8 + c] != empty_code) begin
                    work[dst * 8 + c] = work[r * 8 + c];
                    dst--;
                end
            end
            for (int r = dst; r >= 0; r--) begin
                work[r * 8 + c] = empty_code;
            end
        end
    endtask

    task automatic settle_work();
        bit again;
        again = 1'b1;
        while (again) begin
            compact_work();
            again = find_runs();
            for (int i = 0; i < 64; i++) begin
                if (run_mark[i]) begin
                    work[i] = empty_code;
                end
            end
        end
    endtask

    // swap two cells on a copy of the board and look for runs
    function automatic bit trial_runs(int r, int c, int nr, int nc);
        for (int i = 0; i < 64; i++) begin
            work[i] = mdl[i];
        end
        work[r * 8 + c]   = mdl[nr * 8 + nc];
        work[nr * 8 + nc] = mdl[r * 8 + c];
        return find_runs();
    endfunction

    // --------------------
    // DUT access
    // --------------------
    task automatic pulse(int act);
        @(posedge clk);
        case (act)
            a_left:  left <= 1'b1;
            a_right: right <= 1'b1;
            a_up:    up <= 1'b1;
            a_down:  down <= 1'b1;
            a_enter: enter <= 1'b1;
            a_enter_right: begin
                enter <= 1'b1;
                right <= 1'b1;
            end
            a_fill:  game_reset <= 1'b1;
            default: ;
        endcase
        @(posedge clk);
        left       <= 1'b0;
        right      <= 1'b0;
        up         <= 1'b0;
        down       <= 1'b0;
        enter      <= 1'b0;
        game_reset <= 1'b0;
    endtask

    task automatic expect_state(int row, int col, bit sel, bit bsy);
        exp_row   <= row_t'(row);
        exp_col   <= col_t'(col);
        exp_sel   <= sel;
        exp_busy  <= bsy;
        exp_valid <= 1'b1;
        @(posedge clk);
        exp_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // codes 5 and 6 become empty here so the later compare flags them
    task automatic capture_board();
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            rd_row <= row_t'(i / 8);
            rd_col <= col_t'(i % 8);
            @(negedge clk);
            work[i] = (rd_cell < gem_kinds) ? int'(rd_cell) : empty_code;
        end
    endtask

    task automatic compare_board();
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            rd_row     <= row_t'(i / 8);
            rd_col     <= col_t'(i % 8);
            exp_cell   <= cell_t'(mdl[i]);
            cell_valid <= 1'b1;
        end
        @(posedge clk);
        cell_valid <= 1'b0;
    endtask

    // --------------------
    // actions
    // --------------------
    task automatic apply_entry(int act, int row, int col, bit sel);
        int nr;
        int nc;
        bit kept;
        kept = 1'b0;
        nr   = cur_r;
        nc   = cur_c;
        // a direction with a selection tries a swap
        if (act <= a_down && cur_sel) begin
            case (act)
                a_left:  nc--;
                a_right: nc++;
                a_up:    nr--;
                default: nr++;
            endcase
            if (nr >= 0 && nr < 8 && nc >= 0 && nc < 8) begin
                kept = trial_runs(cur_r, cur_c, nr, nc);
            end
        end
        pulse(act);
        expect_state(row, col, sel, kept || act == a_fill);
        if (kept || act == a_fill) begin
            // pulses during a settle must leave cursor and selection alone
            pulse(a_left);
            pulse(a_right);
            pulse(a_enter);
            wait_idle();
            if (act == a_fill) begin
                capture_board();
            end
            settle_work();
            for (int i = 0; i < 64; i++) begin
                mdl[i] = work[i];
            end
        end
        cur_r   = row;
        cur_c   = col;
        cur_sel = sel;
        compare_board();
    endtask

    // find a swap of two different cells with or without a run, walk there and make it
    task automatic hunt_swap(bit want_run);
        int tr;
        int tc;
        int td;
        bit found;
        found = 1'b0;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                if (!found && c < 7 && mdl[r * 8 + c] != mdl[r * 8 + c + 1]
                        && trial_runs(r, c, r, c + 1) == want_run) begin
                    found = 1'b1;
                    tr = r;
                    tc = c;
                    td = a_right;
                end
                if (!found && r < 7 && mdl[r * 8 + c] != mdl[(r + 1) * 8 + c]
                        && trial_runs(r, c, r + 1, c) == want_run) begin
                    found = 1'b1;
                    tr = r;
                    tc = c;
                    td = a_down;
                end
            end
        end
        if (!found) begin
            $display("note: no suitable swap on this board, hunt skipped");
        end else begin
            if (cur_sel) begin
                apply_entry(a_enter, cur_r, cur_c, 1'b0);
            end
            while (cur_c < tc) apply_entry(a_right, cur_r, cur_c + 1, 1'b0);
            while (cur_c > tc) apply_entry(a_left, cur_r, cur_c - 1, 1'b0);
            while (cur_r < tr) apply_entry(a_down, cur_r + 1, cur_c, 1'b0);
            while (cur_r > tr) apply_entry(a_up, cur_r - 1, cur_c, 1'b0);
            apply_entry(a_enter, tr, tc, 1'b1);
            apply_entry(td, tr, tc, 1'b0);
        end
    endtask

    task automatic add_entry(int act, int row, int col, bit sel);
        tbl_act[n_entries] = act;
        tbl_row[n_entries] = row;
        tbl_col[n_entries] = col;
        tbl_sel[n_entries] = sel;
        n_entries++;
    endtask

    task automatic build_table();
        n_entries = 0;
        add_entry(a_up, 0, 0, 0);
        add_entry(a_left, 0, 0, 0);
        add_entry(a_right, 0, 1, 0);
        add_entry(a_down, 1, 1, 0);
        // swaps on the empty board never make a run
        add_entry(a_enter, 1, 1, 1);
        add_entry(a_right, 1, 1, 0);
        add_entry(a_enter, 1, 1, 1);
        add_entry(a_enter_right, 1, 1, 0);
        add_entry(a_enter, 1, 1, 1);
        add_entry(a_up, 1, 1, 0);
        add_entry(a_left, 1, 0, 0);
        add_entry(a_enter, 1, 0, 1);
        add_entry(a_left, 1, 0, 0);
        for (int r = 2; r <= 8; r++) begin
            add_entry(a_down, (r > 7) ? 7 : r, 0, 0);
        end
        for (int c = 1; c <= 8; c++) begin
            add_entry(a_right, 7, (c > 7) ? 7 : c, 0);
        end
        add_entry(a_enter, 7, 7, 1);
        add_entry(a_down, 7, 7, 0);
        add_entry(a_fill, 7, 7, 0);
        add_entry(a_enter, 7, 7, 1);
        add_entry(a_up, 7, 7, 0);
        // hunt rows take their cursor values from the search
        add_entry(a_hunt, 0, 0, 0);
        add_entry(a_miss, 0, 0, 0);
        add_entry(a_hunt, 0, 0, 0);
        add_entry(a_fill, 0, 0, 0);
        add_entry(a_miss, 0, 0, 0);
        add_entry(a_hunt, 0, 0, 0);
        add_entry(a_hunt, 0, 0, 0);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        left        = 1'b0;
        right       = 1'b0;
        up          = 1'b0;
        down        = 1'b0;
        enter       = 1'b0;
        game_reset  = 1'b0;
        rd_row      = '0;
        rd_col      = '0;
        exp_valid   = 1'b0;
        exp_row     = '0;
        exp_col     = '0;
        exp_sel     = 1'b0;
        exp_busy    = 1'b0;
        cell_valid  = 1'b0;
        exp_cell    = '0;
        cycles      = 0;
        cycle_limit = 0;
        cur_r       = 0;
        cur_c       = 0;
        cur_sel     = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mdl[i] = empty_code;
        end
        build_table();
        cycle_limit = n_entries * (64 * 8 + 4096);

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        expect_state(0, 0, 1'b0, 1'b0);
        compare_board();

        for (int i = 0; i < n_entries; i++) begin
            if (tbl_act[i] == a_hunt || tbl_act[i] == a_miss) begin
                hunt_swap(tbl_act[i] == a_hunt);
            end else begin
                // fill rows keep the cursor where it is
                if (tbl_act[i] == a_fill) begin
                    apply_entry(a_fill, cur_r, cur_c, cur_sel);
                end else begin
                    apply_entry(tbl_act[i], tbl_row[i], tbl_col[i], tbl_sel[i]);
                end
            end
        end

        @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
